/* source/mmu_pkg.sv */
// --------------------------------------------------------------------------
// Shared definitions for the data MMU subsystem
// TLB sizing, field typedefs and packed structs
// CP0 register select, exception codes and register field positions
// --------------------------------------------------------------------------
package mmu_pkg;

    // TLB sizing
    localparam int TLB_WIDTH   = 3;
    localparam int TLB_ENTRIES = 8;

    typedef logic [31:0]          word_t;
    typedef logic [18:0]          vpn2_t;
    typedef logic [7:0]           asid_t;
    typedef logic [19:0]          pfn_t;
    typedef logic [2:0]           cbits_t;
    typedef logic [TLB_WIDTH-1:0] tlb_idx_t;
    typedef logic [15:0]          mask_t;
    typedef logic [4:0]           exc_code_t;

    // --------------------------------------------------------------------------
    // Structs
    // --------------------------------------------------------------------------
    typedef struct packed {
        cbits_t c;
        logic   d;
        logic   v;
    } tlb_flags_t;

    typedef struct packed {
        vpn2_t      vpn2;
        asid_t      asid;
        mask_t      mask;
        logic       g;
        pfn_t       pfn0;
        tlb_flags_t flags0;
        pfn_t       pfn1;
        tlb_flags_t flags1;
    } tlb_entry_t;

    // Search result, page already chosen by the odd bit
    typedef struct packed {
        logic     hit;
        tlb_idx_t index;
        pfn_t     pfn;
        cbits_t   c;
        logic     d;
        logic     v;
    } tlb_lookup_t;

    typedef struct packed {
        pfn_t      tag;
        logic      uncache;
        logic      has_exc;
        exc_code_t exc_code;
        logic      refill;
    } mmu_result_t;

    typedef tlb_entry_t tlb_read_t;

    typedef enum logic [2:0] {
        INDEX    = 3'd0,
        RANDOM   = 3'd1,
        ENTRYLO0 = 3'd2,
        ENTRYLO1 = 3'd3,
        PAGEMASK = 3'd4,
        ENTRYHI  = 3'd5,
        CONFIG   = 3'd6
    } cp0_sel_e;

    // Exception codes
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;

    localparam cbits_t CACHED = 3'd3;

    // Segment codes on vaddr[31:29]
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // --------------------------------------------------------------------------
    // Register field positions
    // --------------------------------------------------------------------------
    localparam int HI_VPN2_LSB = 13;
    localparam int HI_ASID_LSB = 0;
    localparam int LO_PFN_LSB  = 6;
    localparam int LO_C_LSB    = 3;
    localparam int LO_D_BIT    = 2;
    localparam int LO_V_BIT    = 1;
    localparam int LO_G_BIT    = 0;
    localparam int IDX_P_BIT   = 31;
    localparam int IDX_LSB     = 0;
    localparam int PM_MASK_LSB = 13;
    localparam int CFG_K0_LSB  = 0;

endpackage

/* source/cp0_tlb_regs.sv */
// --------------------------------------------------------------------------
// CP0 TLB management registers
// EntryHi, EntryLo0/1, PageMask, Index, Random and Config
// Host read/write port plus TLBP and TLBR write-back
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module cp0_tlb_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cp0_we_i,
    input  mmu_pkg::cp0_sel_e   cp0_sel_i,
    input  mmu_pkg::word_t      cp0_wdata_i,
    input  logic                tlbp_wb_i,
    input  mmu_pkg::word_t      index_wb_i,
    input  logic                tlbr_wb_i,
    input  mmu_pkg::tlb_entry_t tlbr_wb_data_i,
    output mmu_pkg::word_t      cp0_rdata_o,
    output mmu_pkg::word_t      entry_hi_o,
    output mmu_pkg::word_t      entry_lo0_o,
    output mmu_pkg::word_t      entry_lo1_o,
    output mmu_pkg::word_t      page_mask_o,
    output mmu_pkg::word_t      index_o,
    output mmu_pkg::word_t      random_o,
    output mmu_pkg::word_t      config_o
);
    import mmu_pkg::*;

    word_t    entry_hi_q;
    word_t    entry_lo0_q;
    word_t    entry_lo1_q;
    word_t    page_mask_q;
    word_t    index_q;
    word_t    config_q;
    tlb_idx_t random_q;

    // Random free-runs downward, 0 wraps to the top entry
    always_ff @(posedge clk) begin
        if (!rst) begin
            random_q <= tlb_idx_t'(TLB_ENTRIES - 1);
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            entry_hi_q  <= '0;
            entry_lo0_q <= '0;
            entry_lo1_q <= '0;
            page_mask_q <= '0;
            index_q     <= '0;
            config_q    <= word_t'(CACHED) << CFG_K0_LSB;
        end else begin
            if (cp0_we_i) begin
                case (cp0_sel_i)
                    INDEX:    index_q     <= cp0_wdata_i;
                    ENTRYLO0: entry_lo0_q <= cp0_wdata_i;
                    ENTRYLO1: entry_lo1_q <= cp0_wdata_i;
                    PAGEMASK: page_mask_q <= cp0_wdata_i;
                    ENTRYHI:  entry_hi_q  <= cp0_wdata_i;
                    CONFIG:   config_q    <= cp0_wdata_i;
                    default:  ;
                endcase
            end
            // Write-back after the host write so it takes priority
            if (tlbp_wb_i) begin
                index_q <= index_wb_i;
            end
            if (tlbr_wb_i) begin
                entry_hi_q  <= {tlbr_wb_data_i.vpn2, 5'b0, tlbr_wb_data_i.asid};
                entry_lo0_q <= {6'b0, tlbr_wb_data_i.pfn0, tlbr_wb_data_i.flags0,
                                tlbr_wb_data_i.g};
                entry_lo1_q <= {6'b0, tlbr_wb_data_i.pfn1, tlbr_wb_data_i.flags1,
                                tlbr_wb_data_i.g};
                page_mask_q <= {3'b0, tlbr_wb_data_i.mask, 13'b0};
            end
        end
    end

    // Host read mux
    always_comb begin
        case (cp0_sel_i)
            INDEX:    cp0_rdata_o = index_q;
            RANDOM:   cp0_rdata_o = word_t'(random_q);
            ENTRYLO0: cp0_rdata_o = entry_lo0_q;
            ENTRYLO1: cp0_rdata_o = entry_lo1_q;
            PAGEMASK: cp0_rdata_o = page_mask_q;
            ENTRYHI:  cp0_rdata_o = entry_hi_q;
            CONFIG:   cp0_rdata_o = config_q;
            default:  cp0_rdata_o = '0;
        endcase
    end

    assign entry_hi_o  = entry_hi_q;
    assign entry_lo0_o = entry_lo0_q;
    assign entry_lo1_o = entry_lo1_q;
    assign page_mask_o = page_mask_q;
    assign index_o     = index_q;
    assign random_o    = word_t'(random_q);
    assign config_o    = config_q;

endmodule

/* source/data_mmu.sv */
// --------------------------------------------------------------------------
// Data-side MMU
// Segment decode and TLB lookup request for data accesses and TLBP
// Tag, uncached flag and TLB exception selection
// Entry formatting for TLBWI/TLBWR, TLBR and TLBP write-back
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module data_mmu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 data_req_i,
    input  logic                 data_wr_i,
    input  logic                 data_index_ok_i,
    input  mmu_pkg::word_t       vaddr_i,
    input  logic                 tlbp_i,
    input  logic                 tlbr_i,
    input  logic                 tlbwi_i,
    input  logic                 tlbwr_i,
    input  mmu_pkg::word_t       entry_hi_i,
    input  mmu_pkg::word_t       entry_lo0_i,
    input  mmu_pkg::word_t       entry_lo1_i,
    input  mmu_pkg::word_t       page_mask_i,
    input  mmu_pkg::word_t       index_i,
    input  mmu_pkg::word_t       random_i,
    input  mmu_pkg::word_t       config_i,
    input  mmu_pkg::tlb_lookup_t lookup_i,
    input  mmu_pkg::tlb_entry_t  rd_entry_i,
    output mmu_pkg::mmu_result_t result_o,
    output logic                 lk_req_o,
    output mmu_pkg::vpn2_t       lk_vpn2_o,
    output logic                 lk_odd_o,
    output mmu_pkg::asid_t       lk_asid_o,
    output logic                 we_o,
    output mmu_pkg::tlb_idx_t    w_index_o,
    output mmu_pkg::tlb_entry_t  w_entry_o,
    output logic                 re_o,
    output mmu_pkg::tlb_idx_t    r_index_o,
    output logic                 tlbp_wb_o,
    output mmu_pkg::word_t       index_wb_o,
    output logic                 tlbr_wb_o,
    output mmu_pkg::tlb_read_t   tlbr_wb_data_o
);
    import mmu_pkg::*;

    logic data_req;
    logic req_q;
    logic mapped_q;
    logic kseg1_q;
    logic store_q;
    logic k0_uncache_q;
    pfn_t unmap_tag_q;
    logic miss_or_inv;
    logic mod_exc;
    logic has_exc;

    // EntryLo flag bits into the TLB flag layout
    function automatic tlb_flags_t lo_flags(input word_t lo);
        tlb_flags_t f;
        f.c = cbits_t'(lo >> LO_C_LSB);
        f.d = lo[LO_D_BIT];
        f.v = lo[LO_V_BIT];
        return f;
    endfunction

    // --------------------------------------------------------------------------
    // Lookup request
    // --------------------------------------------------------------------------
    assign data_req  = data_req_i && data_index_ok_i;
    assign lk_req_o  = data_req || tlbp_i;
    // TLBP probes with EntryHi, data accesses with the virtual address
    assign lk_vpn2_o = tlbp_i ? vpn2_t'(entry_hi_i >> HI_VPN2_LSB) : vaddr_i[31:13];
    assign lk_odd_o  = vaddr_i[12] && !tlbp_i;
    assign lk_asid_o = asid_t'(entry_hi_i >> HI_ASID_LSB);

    always_ff @(posedge clk) begin
        if (!rst) begin
            req_q        <= 1'b0;
            mapped_q     <= 1'b0;
            kseg1_q      <= 1'b0;
            store_q      <= 1'b0;
            k0_uncache_q <= 1'b0;
        end else begin
            req_q <= data_req;
            if (lk_req_o) begin
                mapped_q     <= vaddr_i[31:29] != SEG_KSEG0 && vaddr_i[31:29] != SEG_KSEG1;
                kseg1_q      <= vaddr_i[31:29] == SEG_KSEG1;
                store_q      <= data_wr_i;
                k0_uncache_q <= cbits_t'(config_i >> CFG_K0_LSB) != CACHED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk_req_o) begin
            unmap_tag_q <= {3'b0, vaddr_i[28:12]};
        end
    end

    // --------------------------------------------------------------------------
    // Translation result
    // --------------------------------------------------------------------------
    assign miss_or_inv = !lookup_i.hit || !lookup_i.v;
    assign mod_exc     = !miss_or_inv && store_q && !lookup_i.d;
    assign has_exc     = req_q && mapped_q && (miss_or_inv || mod_exc);

    always_comb begin
        result_o = '0;
        if (req_q) begin
            result_o.tag     = mapped_q ? lookup_i.pfn : unmap_tag_q;
            result_o.uncache = mapped_q ? (lookup_i.c != CACHED) : (kseg1_q || k0_uncache_q);
            result_o.has_exc = has_exc;
            if (has_exc) begin
                // MOD only on a valid hit, else TLBL or TLBS by direction
                result_o.exc_code = mod_exc ? EXC_MOD : (store_q ? EXC_TLBS : EXC_TLBL);
                result_o.refill   = !lookup_i.hit;
            end
        end
    end

    // --------------------------------------------------------------------------
    // TLB write, read and probe
    // --------------------------------------------------------------------------
    assign we_o      = tlbwi_i || tlbwr_i;
    assign w_index_o = tlbwi_i ? tlb_idx_t'(index_i >> IDX_LSB) : tlb_idx_t'(random_i >> IDX_LSB);

    always_comb begin
        w_entry_o.vpn2   = vpn2_t'(entry_hi_i >> HI_VPN2_LSB);
        w_entry_o.asid   = asid_t'(entry_hi_i >> HI_ASID_LSB);
        w_entry_o.mask   = mask_t'(page_mask_i >> PM_MASK_LSB);
        // Global only if both halves say so
        w_entry_o.g      = entry_lo0_i[LO_G_BIT] && entry_lo1_i[LO_G_BIT];
        w_entry_o.pfn0   = pfn_t'(entry_lo0_i >> LO_PFN_LSB);
        w_entry_o.flags0 = lo_flags(entry_lo0_i);
        w_entry_o.pfn1   = pfn_t'(entry_lo1_i >> LO_PFN_LSB);
        w_entry_o.flags1 = lo_flags(entry_lo1_i);
    end

    assign re_o           = tlbr_i;
    assign r_index_o      = tlb_idx_t'(index_i >> IDX_LSB);
    assign tlbr_wb_data_o = rd_entry_i;

    // Probe result, P set on a miss
    always_comb begin
        index_wb_o                          = '0;
        index_wb_o[IDX_P_BIT]               = !lookup_i.hit;
        index_wb_o[IDX_LSB +: TLB_WIDTH]    = lookup_i.index;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tlbp_wb_o <= 1'b0;
            tlbr_wb_o <= 1'b0;
        end else begin
            tlbp_wb_o <= tlbp_i;
            tlbr_wb_o <= tlbr_i;
        end
    end

endmodule

/* source/tlb_array.sv */
// --------------------------------------------------------------------------
// Fully associative joint TLB, eight entries
// Registered parallel search with odd/even page select
// Registered indexed read and single-cycle indexed write
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tlb_array (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lk_req_i,
    input  mmu_pkg::vpn2_t       lk_vpn2_i,
    input  logic                 lk_odd_i,
    input  mmu_pkg::asid_t       lk_asid_i,
    input  logic                 we_i,
    input  mmu_pkg::tlb_idx_t    w_index_i,
    input  mmu_pkg::tlb_entry_t  w_entry_i,
    input  logic                 re_i,
    input  mmu_pkg::tlb_idx_t    r_index_i,
    output mmu_pkg::tlb_lookup_t lookup_o,
    output mmu_pkg::tlb_entry_t  rd_entry_o
);
    import mmu_pkg::*;

    tlb_entry_t              entries_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]  match;
    tlb_lookup_t             lookup_d;

    // Match on vpn2, and on asid unless the entry is global
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = entries_q[i].vpn2 == lk_vpn2_i &&
                       (entries_q[i].g || entries_q[i].asid == lk_asid_i);
        end
    end

    // Lowest matching index wins if software left duplicates
    always_comb begin
        lookup_d = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                lookup_d.hit   = 1'b1;
                lookup_d.index = tlb_idx_t'(i);
                lookup_d.pfn   = lk_odd_i ? entries_q[i].pfn1 : entries_q[i].pfn0;
                {lookup_d.c, lookup_d.d, lookup_d.v} =
                    lk_odd_i ? entries_q[i].flags1 : entries_q[i].flags0;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Entry storage and search register
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            lookup_o <= '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            if (lk_req_i) begin
                lookup_o <= lookup_d;
            end
            if (we_i) begin
                entries_q[w_index_i] <= w_entry_i;
            end
        end
    end

    // Indexed read for TLBR
    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_entry_o <= entries_q[r_index_i];
        end
    end

endmodule

/* source/mmu_top.sv */
// --------------------------------------------------------------------------
// Data MMU subsystem top level
// CP0 TLB registers, data MMU and joint TLB
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mmu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cp0_we_i,
    input  mmu_pkg::cp0_sel_e    cp0_sel_i,
    input  mmu_pkg::word_t       cp0_wdata_i,
    output mmu_pkg::word_t       cp0_rdata_o,
    input  logic                 tlbp_i,
    input  logic                 tlbr_i,
    input  logic                 tlbwi_i,
    input  logic                 tlbwr_i,
    input  logic                 data_req_i,
    input  logic                 data_wr_i,
    input  logic                 data_index_ok_i,
    input  mmu_pkg::word_t       vaddr_i,
    output mmu_pkg::mmu_result_t mmu_result_o
);
    import mmu_pkg::*;

    // CP0 register words
    word_t       cp0_entry_hi;
    word_t       cp0_entry_lo0;
    word_t       cp0_entry_lo1;
    word_t       cp0_page_mask;
    word_t       cp0_index;
    word_t       cp0_random;
    word_t       cp0_config;

    // Write-back to CP0
    logic        tlbp_wb;
    word_t       index_wb;
    logic        tlbr_wb;
    tlb_read_t   tlbr_wb_data;

    // TLB side
    logic        lk_req;
    vpn2_t       lk_vpn2;
    logic        lk_odd;
    asid_t       lk_asid;
    tlb_lookup_t lookup;
    logic        we;
    tlb_idx_t    w_index;
    tlb_entry_t  w_entry;
    logic        re;
    tlb_idx_t    r_index;
    tlb_entry_t  rd_entry;

    cp0_tlb_regs i_cp0_tlb_regs (
        .clk            (clk),
        .rst            (rst),
        .cp0_we_i       (cp0_we_i),
        .cp0_sel_i      (cp0_sel_i),
        .cp0_wdata_i    (cp0_wdata_i),
        .tlbp_wb_i      (tlbp_wb),
        .index_wb_i     (index_wb),
        .tlbr_wb_i      (tlbr_wb),
        .tlbr_wb_data_i (tlbr_wb_data),
        .cp0_rdata_o    (cp0_rdata_o),
        .entry_hi_o     (cp0_entry_hi),
        .entry_lo0_o    (cp0_entry_lo0),
        .entry_lo1_o    (cp0_entry_lo1),
        .page_mask_o    (cp0_page_mask),
        .index_o        (cp0_index),
        .random_o       (cp0_random),
        .config_o       (cp0_config)
    );

    data_mmu i_data_mmu (
        .clk             (clk),
        .rst             (rst),
        .data_req_i      (data_req_i),
        .data_wr_i       (data_wr_i),
        .data_index_ok_i (data_index_ok_i),
        .vaddr_i         (vaddr_i),
        .tlbp_i          (tlbp_i),
        .tlbr_i          (tlbr_i),
        .tlbwi_i         (tlbwi_i),
        .tlbwr_i         (tlbwr_i),
        .entry_hi_i      (cp0_entry_hi),
        .entry_lo0_i     (cp0_entry_lo0),
        .entry_lo1_i     (cp0_entry_lo1),
        .page_mask_i     (cp0_page_mask),
        .index_i         (cp0_index),
        .random_i        (cp0_random),
        .config_i        (cp0_config),
        .lookup_i        (lookup),
        .rd_entry_i      (rd_entry),
        .result_o        (mmu_result_o),
        .lk_req_o        (lk_req),
        .lk_vpn2_o       (lk_vpn2),
        .lk_odd_o        (lk_odd),
        .lk_asid_o       (lk_asid),
        .we_o            (we),
        .w_index_o       (w_index),
        .w_entry_o       (w_entry),
        .re_o            (re),
        .r_index_o       (r_index),
        .tlbp_wb_o       (tlbp_wb),
        .index_wb_o      (index_wb),
        .tlbr_wb_o       (tlbr_wb),
        .tlbr_wb_data_o  (tlbr_wb_data)
    );

    tlb_array i_tlb_array (
        .clk        (clk),
        .rst        (rst),
        .lk_req_i   (lk_req),
        .lk_vpn2_i  (lk_vpn2),
        .lk_odd_i   (lk_odd),
        .lk_asid_i  (lk_asid),
        .we_i       (we),
        .w_index_i  (w_index),
        .w_entry_i  (w_entry),
        .re_i       (re),
        .r_index_i  (r_index),
        .lookup_o   (lookup),
        .rd_entry_o (rd_entry)
    );

endmodule

/* test/mmu_checker.sv */
// --------------------------------------------------------------------------
// Assertions bound to the data MMU top level
// Write-back strobes after reset, exception source, refill qualification
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mmu_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tlbp_wb_i,
    input  logic                 tlbr_wb_i,
    input  logic                 data_req_i,
    input  logic                 data_index_ok_i,
    input  mmu_pkg::word_t       vaddr_i,
    input  mmu_pkg::mmu_result_t result_i
);
    import mmu_pkg::*;

    logic mapped_req;

    // Qualified request to a mapped segment
    assign mapped_req = data_req_i && data_index_ok_i &&
                        vaddr_i[31:29] != SEG_KSEG0 && vaddr_i[31:29] != SEG_KSEG1;

    wb_quiet_after_reset: assert property (
        @(posedge clk) $rose(rst) |-> !tlbp_wb_i && !tlbr_wb_i)
        else $error("TLB write-back strobe high in the first cycle after reset");

    exc_from_mapped: assert property (
        @(posedge clk) disable iff (!rst) result_i.has_exc |-> $past(mapped_req))
        else $error("TLB exception without a mapped request in the previous cycle");

    refill_has_exc: assert property (
        @(posedge clk) disable iff (!rst) result_i.refill |-> result_i.has_exc)
        else $error("refill flag set without an exception");

endmodule

bind mmu_top mmu_checker i_mmu_checker (
    .clk             (clk),
    .rst             (rst),
    .tlbp_wb_i       (tlbp_wb),
    .tlbr_wb_i       (tlbr_wb),
    .data_req_i      (data_req_i),
    .data_index_ok_i (data_index_ok_i),
    .vaddr_i         (vaddr_i),
    .result_i        (mmu_result_o)
);

/* test/mmu_top_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the data MMU subsystem
// Clock, reset, stimulus table applied step by step
// Translation, TLBP, TLBR and TLBWR checks against expected values
// Cycle limit and closing summary
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mmu_top_tb;
    import mmu_pkg::*;

    typedef enum logic [3:0] {
        OP_WRITE, OP_READ, OP_DATA, OP_K1, OP_TLBP,
        OP_TLBR, OP_TLBWI, OP_TLBWR, OP_RIDX
    } op_e;

    typedef struct packed {
        op_e      op;
        cp0_sel_e sel;
        word_t    data;
        word_t    vaddr;
        logic     store;
        word_t    exp_val;
        word_t    mask;
    } step_t;

    logic        clk;
    logic        rst;
    logic        cp0_we_i;
    cp0_sel_e    cp0_sel_i;
    word_t       cp0_wdata_i;
    word_t       cp0_rdata_o;
    logic        tlbp_i;
    logic        tlbr_i;
    logic        tlbwi_i;
    logic        tlbwr_i;
    logic        data_req_i;
    logic        data_wr_i;
    logic        data_index_ok_i;
    word_t       vaddr_i;
    mmu_result_t mmu_result_o;

    step_t  steps[$];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     run_cycles;
    int     cycle_limit = 0;
    word_t  rand_exp;

    mmu_top i_mmu_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        // Edges out of reset, each one steps Random down
        if (rst) begin
            run_cycles++;
        end
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    function automatic void add_step(op_e op, cp0_sel_e sel, word_t data, word_t vaddr,
                                     logic store, word_t exp_val, word_t mask);
        steps.push_back('{op, sel, data, vaddr, store, exp_val, mask});
    endfunction

    function automatic void put_reg(cp0_sel_e sel, word_t data);
        add_step(OP_WRITE, sel, data, '0, 1'b0, '0, '0);
    endfunction

    function automatic void expect_reg(cp0_sel_e sel, word_t exp_val, word_t mask);
        add_step(OP_READ, sel, '0, '0, 1'b0, exp_val, mask);
    endfunction

    function automatic void strobe(op_e op);
        add_step(op, INDEX, '0, '0, 1'b0, '0, '0);
    endfunction

    // On an exception only the exception fields are defined
    function automatic void access(word_t vaddr, logic store, pfn_t tag, logic unc,
                                   exc_code_t code, logic refill);
        mmu_result_t r;
        r.tag      = tag;
        r.uncache  = unc;
        r.has_exc  = code != '0;
        r.exc_code = code;
        r.refill   = refill;
        add_step(OP_DATA, INDEX, '0, vaddr, store, word_t'(r),
                 r.has_exc ? 32'h0000_007F : 32'h0FFF_FFFF);
    endfunction

    // --------------------------------------------------------------------------
    // Stimulus table
    // --------------------------------------------------------------------------
    function automatic void build_table();
        // Unmapped segments, Config K0 cached at reset
        access(32'h8001_2345, 1'b0, 20'h00012, 1'b0, '0, 1'b0);
        put_reg(CONFIG, 32'h0000_0002);
        access(32'h9FFF_F000, 1'b1, 20'h1FFFF, 1'b1, '0, 1'b0);
        put_reg(CONFIG, 32'h0000_0003);
        add_step(OP_K1, INDEX, '0, '0, 1'b0, '0, '0);
        add_step(OP_K1, INDEX, '0, '0, 1'b1, '0, '0);
        // Entry 2, asid 5, even page cached, odd page uncached
        put_reg(ENTRYHI, 32'h0008_0005);
        put_reg(ENTRYLO0, 32'h0048_D15E);
        put_reg(ENTRYLO1, 32'h0002_AF12);
        put_reg(PAGEMASK, 32'h0000_6000);
        put_reg(INDEX, 32'h0000_0002);
        strobe(OP_TLBWI);
        access(32'h0008_0123, 1'b0, 20'h12345, 1'b0, '0, 1'b0);
        access(32'h0008_1FFC, 1'b0, 20'h00ABC, 1'b1, '0, 1'b0);
        access(32'h0040_0000, 1'b0, '0, 1'b0, EXC_TLBL, 1'b1);
        // Entry 5 with a clean even page and an invalid odd page
        put_reg(ENTRYHI, 32'h0010_0005);
        put_reg(ENTRYLO0, 32'h0001_DDDA);
        put_reg(ENTRYLO1, 32'h0002_221C);
        put_reg(INDEX, 32'h0000_0005);
        strobe(OP_TLBWI);
        access(32'h0010_1000, 1'b1, '0, 1'b0, EXC_TLBS, 1'b0);
        access(32'h0010_0000, 1'b1, '0, 1'b0, EXC_MOD, 1'b0);
        // Global entry 6 written under asid 9, used under asid 0x33
        put_reg(ENTRYHI, 32'h0018_0009);
        put_reg(ENTRYLO0, 32'h0032_BF9F);
        put_reg(ENTRYLO1, 32'h002F_BBDF);
        put_reg(INDEX, 32'h0000_0006);
        strobe(OP_TLBWI);
        put_reg(ENTRYHI, 32'h0018_0033);
        access(32'h0018_0000, 1'b0, 20'h0CAFE, 1'b0, '0, 1'b0);
        access(32'h0018_1000, 1'b0, 20'h0BEEF, 1'b0, '0, 1'b0);
        // Probe hit and probe miss
        put_reg(ENTRYHI, 32'h0008_0005);
        strobe(OP_TLBP);
        expect_reg(INDEX, 32'h0000_0002, 32'hFFFF_FFFF);
        put_reg(ENTRYHI, 32'h0020_0005);
        strobe(OP_TLBP);
        expect_reg(INDEX, 32'h8000_0000, 32'h8000_0000);
        // Read entry 6 back over cleared registers
        put_reg(INDEX, 32'h0000_0006);
        put_reg(ENTRYHI, 32'h0000_0000);
        put_reg(ENTRYLO0, 32'h0000_0000);
        put_reg(ENTRYLO1, 32'h0000_0000);
        put_reg(PAGEMASK, 32'h0000_0000);
        strobe(OP_TLBR);
        expect_reg(ENTRYHI, 32'h0018_0009, 32'hFFFF_FFFF);
        expect_reg(ENTRYLO0, 32'h0032_BF9F, 32'hFFFF_FFFF);
        expect_reg(ENTRYLO1, 32'h002F_BBDF, 32'hFFFF_FFFF);
        expect_reg(PAGEMASK, 32'h0000_6000, 32'hFFFF_FFFF);
        // Random write, then find it again
        put_reg(ENTRYHI, 32'h0030_0005);
        put_reg(ENTRYLO0, 32'h003C_035E);
        strobe(OP_TLBWR);
        strobe(OP_TLBP);
        strobe(OP_RIDX);
        access(32'h0030_0040, 1'b0, 20'h0F00D, 1'b0, '0, 1'b0);
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t exp_val,
                                input word_t mask);
        checks++;
        assert ((got & mask) == (exp_val & mask)) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got & mask, exp_val & mask);
        end
    endtask

    task automatic run_step(input step_t s);
        @(posedge clk);
        case (s.op)
            OP_WRITE: begin
                cp0_we_i    <= 1'b1;
                cp0_sel_i   <= s.sel;
                cp0_wdata_i <= s.data;
            end
            OP_READ, OP_RIDX: cp0_sel_i <= s.sel;
            OP_DATA, OP_K1: begin
                data_req_i      <= 1'b1;
                data_index_ok_i <= 1'b1;
                data_wr_i       <= s.store;
                vaddr_i         <= s.vaddr;
            end
            OP_TLBP:  tlbp_i  <= 1'b1;
            OP_TLBR:  tlbr_i  <= 1'b1;
            OP_TLBWI: tlbwi_i <= 1'b1;
            OP_TLBWR: begin
                tlbwr_i   <= 1'b1;
                cp0_sel_i <= RANDOM;
            end
            default: ;
        endcase
        // Random that the write uses at the coming edge, down from 7 since reset
        @(negedge clk);
        if (s.op == OP_TLBWR) begin
            rand_exp = word_t'((TLB_ENTRIES - 1 - run_cycles) & (TLB_ENTRIES - 1));
            compare_word("cp0_rdata_o", cp0_rdata_o, rand_exp, 32'hFFFF_FFFF);
        end
        @(posedge clk);
        cp0_we_i        <= 1'b0;
        data_req_i      <= 1'b0;
        data_index_ok_i <= 1'b0;
        tlbp_i          <= 1'b0;
        tlbr_i          <= 1'b0;
        tlbwi_i         <= 1'b0;
        tlbwr_i         <= 1'b0;
        @(negedge clk);
        if (s.op == OP_DATA || s.op == OP_K1) begin
            compare_word("mmu_result_o", word_t'(mmu_result_o), s.exp_val, s.mask);
        end else if (s.op == OP_READ) begin
            compare_word("cp0_rdata_o", cp0_rdata_o, s.exp_val, s.mask);
        end else if (s.op == OP_RIDX) begin
            compare_word("cp0_rdata_o", cp0_rdata_o, rand_exp, 32'hFFFF_FFFF);
        end
        // Result holds for one cycle only
        @(posedge clk);
        @(negedge clk);
        if (s.op == OP_DATA || s.op == OP_K1) begin
            compare_word("mmu_result_o", word_t'(mmu_result_o), '0, 32'hFFFF_FFFF);
        end
    endtask

    // --------------------------------------------------------------------------
    // Main sequence
    // --------------------------------------------------------------------------
    initial begin
        step_t       s;
        mmu_result_t r;
        seed            = 32'hc1f0;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        run_cycles      = 0;
        rand_exp        = '0;
        rst             = 1'b0;
        cp0_we_i        = 1'b0;
        cp0_sel_i       = INDEX;
        cp0_wdata_i     = '0;
        tlbp_i          = 1'b0;
        tlbr_i          = 1'b0;
        tlbwi_i         = 1'b0;
        tlbwr_i         = 1'b0;
        data_req_i      = 1'b0;
        data_wr_i       = 1'b0;
        data_index_ok_i = 1'b0;
        vaddr_i         = '0;
        build_table();
        cycle_limit = 2 * steps.size() * 4;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            // kseg1 access at a random offset, unmapped and uncached
            if (s.op == OP_K1) begin
                s.vaddr   = {3'b101, 29'($random(seed))};
                r         = '0;
                r.tag     = {3'b000, s.vaddr[28:12]};
                r.uncache = 1'b1;
                s.exp_val = word_t'(r);
                s.mask    = 32'h0FFF_FFFF;
            end
            run_step(s);
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dmmu_sub.f */
source/mmu_pkg.sv
source/cp0_tlb_regs.sv
source/data_mmu.sv
source/tlb_array.sv
source/mmu_top.sv
test/mmu_checker.sv
test/mmu_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the data MMU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f dmmu_sub.f --top-module mmu_top_tb &&
    ./obj_dir/Vmmu_top_tb | tee /dev/stderr | grep -qx "test passed" &&
    echo "simulation result: PASS" ||
    { echo "simulation result: FAIL"; exit 1; }
